//--- list.f
+incdir+bench
source/demosaic_frame_pkg.sv
source/demosaic_pixel_pkg.sv
source/bayer_window.sv
source/green_interp.sv
source/chroma_interp.sv
source/border_output.sv
source/isp_demosaic.sv
bench/tb_isp_demosaic.sv

//--- Makefile
# Verilator build and run of the demosaic testbench

VERILATOR ?= verilator
TOP       ?= tb_isp_demosaic
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
FAIL_MSG  ?= Simulation failed

SOURCES := $(shell grep -v '^+' $(FILELIST)) bench/demosaic_ref.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/demosaic_ref.svh
// Demosaic reference model
// expected RGB of one pixel of the stored raw frame: border copy,
// gradient-directed green and colour-difference red and blue
`ifndef DEMOSAIC_REF_SVH
`define DEMOSAIC_REF_SVH

localparam int PIX_MAX = (1 << PIX_BITS) - 1;

pix_t ref_frame [FRAME_HEIGHT][FRAME_WIDTH];    // raw frame the model works on

// colour letter of a pixel from the pattern of (0,0)
function automatic byte colour_at(input int y, input int x);
    string order;
    case (BAYER_PATTERN)
        RGGB:    order = "RGGB";
        GRBG:    order = "GRBG";
        GBRG:    order = "GBRG";
        default: order = "BGGR";
    endcase
    return order[(y % 2) * 2 + (x % 2)];
endfunction

function automatic int raw_at(input int y, input int x);
    return int'(ref_frame[y][x]);
endfunction

function automatic int clamp_pix(input int v);
    if (v < 0)
        return 0;
    if (v > PIX_MAX)
        return PIX_MAX;
    return v;
endfunction

// green anywhere; follows the flatter direction, four-way on a tie
function automatic int green_at(input int y, input int x);
    int dh;
    int dv;
    if (colour_at(y, x) == "G")
        return raw_at(y, x);
    dh = raw_at(y, x - 1) - raw_at(y, x + 1);
    dv = raw_at(y - 1, x) - raw_at(y + 1, x);
    if (dh < 0)
        dh = -dh;
    if (dv < 0)
        dv = -dv;
    if (dh < dv)
        return (raw_at(y, x - 1) + raw_at(y, x + 1)) / 2;
    if (dv < dh)
        return (raw_at(y - 1, x) + raw_at(y + 1, x)) / 2;
    return (raw_at(y, x - 1) + raw_at(y, x + 1) + raw_at(y - 1, x) + raw_at(y + 1, x)) / 4;
endfunction

// missing colour from the two samples at +-(dy,dx)
function automatic int pair_chroma(input int y, input int x, input int g,
                                   input int dy, input int dx);
    int c_avg;
    int g_avg;
    c_avg = (raw_at(y - dy, x - dx) + raw_at(y + dy, x + dx)) / 2;
    g_avg = (green_at(y - dy, x - dx) + green_at(y + dy, x + dx)) / 2;
    return clamp_pix(g + c_avg - g_avg);
endfunction

// missing colour from the four diagonal samples
function automatic int diag_chroma(input int y, input int x, input int g);
    int c_avg;
    int g_avg;
    c_avg = (raw_at(y - 1, x - 1) + raw_at(y - 1, x + 1)
           + raw_at(y + 1, x - 1) + raw_at(y + 1, x + 1)) / 4;
    g_avg = (green_at(y - 1, x - 1) + green_at(y - 1, x + 1)
           + green_at(y + 1, x - 1) + green_at(y + 1, x + 1)) / 4;
    return clamp_pix(g + c_avg - g_avg);
endfunction

// packed as r, g, b from the top
function automatic logic [3*PIX_BITS-1:0] expected_rgb(input int y, input int x);
    int g;
    int r;
    int b;
    if (y < 2 || y >= FRAME_HEIGHT - 2 || x < 2 || x >= FRAME_WIDTH - 2)
        return {3{ref_frame[y][x]}};                // border ring
    g = green_at(y, x);
    case (colour_at(y, x))
        "R": begin
            r = raw_at(y, x);
            b = diag_chroma(y, x, g);
        end
        "B": begin
            r = diag_chroma(y, x, g);
            b = raw_at(y, x);
        end
        default: begin
            if (colour_at(y, x - 1) == "R") begin     // green on a red row
                r = pair_chroma(y, x, g, 0, 1);
                b = pair_chroma(y, x, g, 1, 0);
            end else begin
                r = pair_chroma(y, x, g, 1, 0);
                b = pair_chroma(y, x, g, 0, 1);
            end
        end
    endcase
    return {pix_t'(r), pix_t'(g), pix_t'(b)};
endfunction

`endif

//--- bench/tb_isp_demosaic.sv
// Demosaic testbench
// sends raw test frames through the DUT and checks every RGB pixel against a model
`timescale 1ns/1ps

module tb_isp_demosaic
    import demosaic_pixel_pkg::*;
    import demosaic_frame_pkg::*;
();

localparam int LINE_CYCLES    = FRAME_WIDTH + MIN_HBLANK;
localparam int FRAME_CYCLES   = 1 + MIN_HBLANK + (FRAME_HEIGHT + MIN_VBLANK_LINES) * LINE_CYCLES;
localparam int NUM_FRAMES     = 7;
localparam int IDLE_CYCLES    = 20;     // quiet check after reset
localparam int TIMEOUT_CYCLES = 3 * (4 + IDLE_CYCLES + NUM_FRAMES * FRAME_CYCLES) / 2;
localparam logic [31:0] RAND_SEED = 32'h20ed;

typedef enum {FLAT, NOISE, V_STRIPES, H_STRIPES, EXTREMES} frame_kind_e;

logic pclk;
logic rst_n;
logic in_vsync;
logic in_href;
pix_t in_raw;
logic out_href;
logic out_vsync;
pix_t out_r;
pix_t out_g;
pix_t out_b;

logic [3*PIX_BITS-1:0] exp_q [$];       // expected pixels in raster order
frame_kind_e kinds [NUM_FRAMES];
string       names [NUM_FRAMES];
int   error_count  = 0;
int   tests_run    = 0;
int   tests_failed = 0;
int   frames_done  = 0;
int   cycle_cnt    = 0;
int   vsync_pulses = 0;
int   line_cnt     = 0;
int   col_idx      = 0;
int   frame_errors = 0;
int   start_errors;
logic frame_open   = 1'b0;
logic href_d       = 1'b0;

`include "demosaic_ref.svh"

isp_demosaic uut (
    .pclk      (pclk),
    .rst_n     (rst_n),
    .in_vsync  (in_vsync),
    .in_href   (in_href),
    .in_raw    (in_raw),
    .out_href  (out_href),
    .out_vsync (out_vsync),
    .out_r     (out_r),
    .out_g     (out_g),
    .out_b     (out_b)
);

initial begin
    pclk = 1'b0;
    forever #20 pclk = ~pclk;
end

always @(posedge pclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
        $display("timeout: run still busy after %0d cycles, %0d frames done",
                 cycle_cnt, frames_done);
        $display("Simulation failed");
        $finish;
    end
end

// ********************
// stimulus
// ********************
function automatic void fill_frame(input frame_kind_e kind);
    for (int y = 0; y < FRAME_HEIGHT; y++) begin
        for (int x = 0; x < FRAME_WIDTH; x++) begin
            case (kind)
                FLAT:      ref_frame[y][x] = pix_t'(108);
                NOISE:     ref_frame[y][x] = pix_t'($urandom);
                V_STRIPES: ref_frame[y][x] = pix_t'((((x >> 1) & 1) != 0 ? 200 : 30) + 2 * y);
                H_STRIPES: ref_frame[y][x] = pix_t'((((y >> 1) & 1) != 0 ? 200 : 30) + 2 * x);
                default:   ref_frame[y][x] = pix_t'(($urandom % 2) * PIX_MAX);   // 0 or full
            endcase
        end
    end
endfunction

function automatic void queue_expected();
    for (int y = 0; y < FRAME_HEIGHT; y++)
        for (int x = 0; x < FRAME_WIDTH; x++)
            exp_q.push_back(expected_rgb(y, x));
endfunction

task automatic drive_frame();
    @(posedge pclk);
    in_vsync <= 1'b1;
    @(posedge pclk);
    in_vsync <= 1'b0;
    repeat (MIN_HBLANK - 1) @(posedge pclk);
    for (int y = 0; y < FRAME_HEIGHT; y++) begin
        for (int x = 0; x < FRAME_WIDTH; x++) begin
            @(posedge pclk);
            in_href <= 1'b1;
            in_raw  <= ref_frame[y][x];
        end
        @(posedge pclk);
        in_href <= 1'b0;
        in_raw  <= '0;
        repeat (MIN_HBLANK - 1) @(posedge pclk);       // rest of the line blanking
    end
    repeat (MIN_VBLANK_LINES * LINE_CYCLES) @(posedge pclk);
endtask

// ********************
// output checks
// ********************
function automatic void note_error();
    error_count++;
    if (frame_open)
        frame_errors++;
endfunction

function automatic void check_value(input string sig, input pix_t got, input pix_t want,
                                    input string where);
    if (got !== want) begin
        $display("ERROR %s at %s: expected %h, got %h", sig, where, want, got);
        note_error();
    end
endfunction

function automatic void close_frame();
    if (line_cnt != FRAME_HEIGHT) begin
        $display("frame %0d ended after %0d lines instead of %0d", frames_done, line_cnt,
                 FRAME_HEIGHT);
        note_error();
    end
    tests_run++;
    if (frame_errors != 0)
        tests_failed++;
    $display("test %0d, %s: %s with %0d errors", frames_done + 2,
             (frames_done < NUM_FRAMES) ? names[frames_done] : "extra frame",
             (frame_errors == 0) ? "ok" : "FAILED", frame_errors);
    frame_open = 1'b0;
    frames_done++;
endfunction

function automatic void check_pixel();
    logic [3*PIX_BITS-1:0] want;
    string where;
    if (!frame_open) begin
        frame_open   = 1'b1;
        frame_errors = 0;
        line_cnt     = 0;
        col_idx      = 0;
        if (vsync_pulses != 1) begin
            $display("frame %0d started after %0d out_vsync pulses instead of one",
                     frames_done, vsync_pulses);
            note_error();
        end
        vsync_pulses = 0;
    end
    where = $sformatf("frame %0d pixel (%0d,%0d)", frames_done, line_cnt, col_idx);
    if (exp_q.size() == 0) begin
        $display("%s came out with no frame pending", where);
        note_error();
    end else begin
        want = exp_q.pop_front();
        check_value("out_r", out_r, want[3*PIX_BITS-1:2*PIX_BITS], where);
        check_value("out_g", out_g, want[2*PIX_BITS-1:PIX_BITS], where);
        check_value("out_b", out_b, want[PIX_BITS-1:0], where);
    end
    col_idx++;
endfunction

function automatic void end_line();
    if (col_idx != FRAME_WIDTH) begin
        $display("frame %0d line %0d held %0d pixels instead of %0d", frames_done, line_cnt,
                 col_idx, FRAME_WIDTH);
        note_error();
    end
    line_cnt++;
    col_idx = 0;
    if (line_cnt == FRAME_HEIGHT)
        close_frame();
endfunction

// output collector on the falling edge
always @(negedge pclk) begin
    if (rst_n) begin
        if (out_vsync) begin
            if (frame_open)
                close_frame();      // frame cut short by the next vsync
            vsync_pulses++;
        end
        if (out_href)
            check_pixel();
        else if (href_d && frame_open)
            end_line();
        href_d = out_href;
    end
end

initial begin
    void'($urandom(RAND_SEED));
    kinds = '{FLAT, NOISE, V_STRIPES, H_STRIPES, EXTREMES, NOISE, NOISE};
    names = '{"flat frame", "random frame", "vertical stripes", "horizontal stripes",
              "extreme values", "back-to-back frame 1", "back-to-back frame 2"};
    rst_n    <= 1'b0;
    in_vsync <= 1'b0;
    in_href  <= 1'b0;
    in_raw   <= '0;
    repeat (4) @(posedge pclk);
    rst_n <= 1'b1;

    // quiet outputs with no input
    start_errors = error_count;
    for (int i = 0; i < IDLE_CYCLES; i++) begin
        @(negedge pclk);
        check_value("out_href", pix_t'(out_href), '0, "idle after reset");
        check_value("out_vsync", pix_t'(out_vsync), '0, "idle after reset");
        check_value("out_r", out_r, '0, "idle after reset");
        check_value("out_g", out_g, '0, "idle after reset");
        check_value("out_b", out_b, '0, "idle after reset");
    end
    tests_run++;
    if (error_count != start_errors)
        tests_failed++;
    $display("test 1, quiet after reset: %s with %0d errors",
             (error_count == start_errors) ? "ok" : "FAILED", error_count - start_errors);

    for (int f = 0; f < NUM_FRAMES; f++) begin
        fill_frame(kinds[f]);
        queue_expected();
        drive_frame();
    end
    while (frames_done < NUM_FRAMES)
        @(posedge pclk);
    if (exp_q.size() != 0) begin
        $display("%0d expected pixels never appeared at the output", exp_q.size());
        note_error();
    end

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0)
        $display("Simulation passed");
    else
        $display("Simulation failed");
    $finish;
end

endmodule

//--- source/isp_demosaic.sv
// Bayer demosaic top level
// raw pixel stream in, RGB stream out with the same framing
`timescale 1ns/1ps

module isp_demosaic
    import demosaic_pixel_pkg::*;
(
    input  logic pclk,
    input  logic rst_n,
    input  logic in_vsync,
    input  logic in_href,
    input  pix_t in_raw,
    output logic out_href,
    output logic out_vsync,
    output pix_t out_r,
    output pix_t out_g,
    output pix_t out_b
);

window_t   win;
site_e     win_site;
logic      win_valid;
logic      win_vsync;
logic      win_border;
pix_t      win_raw;

pix_t      g_center;
quad_pix_t g_near;
pix_t      rb_center;
quad_pix_t rb_near;
site_e     g_site;

pix_t      rgb_r;
pix_t      rgb_g;
pix_t      rgb_b;

bayer_window u_window (
    .pclk       (pclk),
    .rst_n      (rst_n),
    .in_vsync   (in_vsync),
    .in_href    (in_href),
    .in_raw     (in_raw),
    .win        (win),
    .win_site   (win_site),
    .win_valid  (win_valid),
    .win_vsync  (win_vsync),
    .win_border (win_border),
    .win_raw    (win_raw)
);

green_interp u_green (
    .pclk      (pclk),
    .rst_n     (rst_n),
    .win       (win),
    .win_site  (win_site),
    .g_center  (g_center),
    .g_near    (g_near),
    .rb_center (rb_center),
    .rb_near   (rb_near),
    .g_site    (g_site)
);

chroma_interp u_chroma (
    .pclk      (pclk),
    .rst_n     (rst_n),
    .g_center  (g_center),
    .g_near    (g_near),
    .rb_center (rb_center),
    .rb_near   (rb_near),
    .g_site    (g_site),
    .rgb_r     (rgb_r),
    .rgb_g     (rgb_g),
    .rgb_b     (rgb_b)
);

border_output u_output (
    .pclk       (pclk),
    .rst_n      (rst_n),
    .win_valid  (win_valid),
    .win_vsync  (win_vsync),
    .win_border (win_border),
    .win_raw    (win_raw),
    .rgb_r      (rgb_r),
    .rgb_g      (rgb_g),
    .rgb_b      (rgb_b),
    .out_href   (out_href),
    .out_vsync  (out_vsync),
    .out_r      (out_r),
    .out_g      (out_g),
    .out_b      (out_b)
);

endmodule

//--- source/border_output.sv
// Demosaic output stage
// aligns framing with the pipeline, copies raw on the border ring
`timescale 1ns/1ps

module border_output
    import demosaic_pixel_pkg::*;
    import demosaic_frame_pkg::*;
(
    input  logic pclk,
    input  logic rst_n,
    input  logic win_valid,
    input  logic win_vsync,
    input  logic win_border,
    input  pix_t win_raw,
    input  pix_t rgb_r,
    input  pix_t rgb_g,
    input  pix_t rgb_b,
    output logic out_href,
    output logic out_vsync,
    output pix_t out_r,
    output pix_t out_g,
    output pix_t out_b
);

logic [PIPE_LATENCY-2:0] valid_sr;    // top bit lines up with rgb
logic [PIPE_LATENCY-2:0] vsync_sr;
logic [PIPE_LATENCY-2:0] border_sr;
pix_t                    raw_sr [PIPE_LATENCY-1];
col_cnt_t                href_run;    // length of the current out_href run

always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
        valid_sr  <= '0;
        vsync_sr  <= '0;
        border_sr <= '0;
    end else begin
        valid_sr  <= {valid_sr[PIPE_LATENCY-3:0], win_valid};
        vsync_sr  <= {vsync_sr[PIPE_LATENCY-3:0], win_vsync};
        border_sr <= {border_sr[PIPE_LATENCY-3:0], win_border};
    end
end

always_ff @(posedge pclk) begin
    raw_sr[0] <= win_raw;
    for (int i = 1; i < PIPE_LATENCY - 1; i++)
        raw_sr[i] <= raw_sr[i-1];
end

// ********************
// final select
// ********************
always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
        out_href  <= 1'b0;
        out_vsync <= 1'b0;
        out_r     <= '0;
        out_g     <= '0;
        out_b     <= '0;
    end else begin
        out_href  <= valid_sr[PIPE_LATENCY-2];
        out_vsync <= vsync_sr[PIPE_LATENCY-2];
        if (!valid_sr[PIPE_LATENCY-2]) begin
            out_r <= '0;
            out_g <= '0;
            out_b <= '0;
        end else if (border_sr[PIPE_LATENCY-2]) begin
            out_r <= raw_sr[PIPE_LATENCY-2];        // ring keeps the raw value
            out_g <= raw_sr[PIPE_LATENCY-2];
            out_b <= raw_sr[PIPE_LATENCY-2];
        end else begin
            out_r <= rgb_r;
            out_g <= rgb_g;
            out_b <= rgb_b;
        end
    end
end

always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n)
        href_run <= '0;
    else if (out_href)
        href_run <= href_run + 1'b1;
    else
        href_run <= '0;
end

line_len_a: assert property (@(posedge pclk) disable iff (!rst_n)
    $fell(out_href) |-> href_run == col_cnt_t'(FRAME_WIDTH));

endmodule

//--- source/chroma_interp.sv
// Red and blue reconstruction
// constant colour difference against the interpolated green, clamped to range
`timescale 1ns/1ps

module chroma_interp
    import demosaic_pixel_pkg::*;
(
    input  logic      pclk,
    input  logic      rst_n,
    input  pix_t      g_center,
    input  quad_pix_t g_near,
    input  pix_t      rb_center,
    input  quad_pix_t rb_near,
    input  site_e     g_site,
    output pix_t      rgb_r,
    output pix_t      rgb_g,
    output pix_t      rgb_b
);

pix_t     c_lr, c_ud, c_q;       // raw colour averages
pix_t     g_lr, g_ud, g_q;       // green averages at the same sites
pix_sum_t g_ext;

pix_t     s1_g;
pix_sum_t s1_r_plus;             // G + avg(C), or the raw sample
pix_t     s1_r_minus;            // avg(G at C sites)
pix_sum_t s1_b_plus;
pix_t     s1_b_minus;

function automatic pix_t clamp_diff(input pix_sum_t plus, input pix_t minus);
    pix_sum_t d;
    if (plus < pix_sum_t'(minus))
        return '0;
    d = plus - pix_sum_t'(minus);
    return (|d[PIX_BITS+1:PIX_BITS]) ? '1 : d[PIX_BITS-1:0];
endfunction

always_comb begin
    c_lr  = avg2(quad_pix(rb_near, 0), quad_pix(rb_near, 1));
    c_ud  = avg2(quad_pix(rb_near, 2), quad_pix(rb_near, 3));
    c_q   = avg4(rb_near);
    g_lr  = avg2(quad_pix(g_near, 0), quad_pix(g_near, 1));
    g_ud  = avg2(quad_pix(g_near, 2), quad_pix(g_near, 3));
    g_q   = avg4(g_near);
    g_ext = pix_sum_t'(g_center);
end

// ********************
// stage 1: sums
// ********************
always_ff @(posedge pclk) begin
    s1_g <= g_center;
    case (g_site)
        SITE_R: begin
            s1_r_plus  <= pix_sum_t'(rb_center);
            s1_r_minus <= '0;
            s1_b_plus  <= g_ext + pix_sum_t'(c_q);    // diagonal blues
            s1_b_minus <= g_q;
        end
        SITE_B: begin
            s1_r_plus  <= g_ext + pix_sum_t'(c_q);    // diagonal reds
            s1_r_minus <= g_q;
            s1_b_plus  <= pix_sum_t'(rb_center);
            s1_b_minus <= '0;
        end
        SITE_GR: begin
            s1_r_plus  <= g_ext + pix_sum_t'(c_lr);
            s1_r_minus <= g_lr;
            s1_b_plus  <= g_ext + pix_sum_t'(c_ud);
            s1_b_minus <= g_ud;
        end
        default: begin                                 // green on blue row
            s1_r_plus  <= g_ext + pix_sum_t'(c_ud);
            s1_r_minus <= g_ud;
            s1_b_plus  <= g_ext + pix_sum_t'(c_lr);
            s1_b_minus <= g_lr;
        end
    endcase
end

// ********************
// stage 2: difference and clamp
// ********************
always_ff @(posedge pclk) begin
    rgb_r <= clamp_diff(s1_r_plus, s1_r_minus);
    rgb_g <= s1_g;
    rgb_b <= clamp_diff(s1_b_plus, s1_b_minus);
end

site_known_a: assert property (@(posedge pclk) disable iff (!rst_n)
    !$isunknown(g_site));

endmodule

//--- source/green_interp.sv
// Green interpolation
// gradient-directed green at the window centre and four neighbour sites
`timescale 1ns/1ps

module green_interp
    import demosaic_pixel_pkg::*;
(
    input  logic      pclk,
    input  logic      rst_n,
    input  window_t   win,
    input  site_e     win_site,
    output pix_t      g_center,
    output quad_pix_t g_near,
    output pix_t      rb_center,
    output quad_pix_t rb_near,
    output site_e     g_site
);

pix_t       wp [25];         // unpacked window
logic [4:0] pos [5];         // 0 is the centre, 1..4 the neighbours
logic       is_green;

site_e      s1_site;
pix_t       s1_dh [5];       // |left - right|
pix_t       s1_dv [5];       // |up - down|
pix_t       s1_ah [5];
pix_t       s1_av [5];
pix_t       s1_a4 [5];
pix_t       s1_raw_c;
quad_pix_t  s1_raw_q;
pix_t       g_sel [5];

function automatic pix_t abs_diff(input pix_t a, input pix_t b);
    return (a > b) ? a - b : b - a;
endfunction

assign is_green = (win_site == SITE_GR) || (win_site == SITE_GB);

always_comb begin
    for (int i = 0; i < 25; i++)
        wp[i] = win[i*PIX_BITS +: PIX_BITS];
    pos[0] = 5'd12;
    if (is_green) begin
        pos[1] = 5'd11;      // left, right, up, down
        pos[2] = 5'd13;
        pos[3] = 5'd7;
        pos[4] = 5'd17;
    end else begin
        pos[1] = 5'd6;       // diagonals UL, UR, DL, DR
        pos[2] = 5'd8;
        pos[3] = 5'd16;
        pos[4] = 5'd18;
    end
end

// ********************
// stage 1: gradients and averages
// ********************
always_ff @(posedge pclk) begin
    for (int k = 0; k < 5; k++) begin
        s1_dh[k] <= abs_diff(wp[pos[k] - 5'd1], wp[pos[k] + 5'd1]);
        s1_dv[k] <= abs_diff(wp[pos[k] - 5'd5], wp[pos[k] + 5'd5]);
        s1_ah[k] <= avg2(wp[pos[k] - 5'd1], wp[pos[k] + 5'd1]);
        s1_av[k] <= avg2(wp[pos[k] - 5'd5], wp[pos[k] + 5'd5]);
        s1_a4[k] <= avg4({wp[pos[k] + 5'd5], wp[pos[k] - 5'd5],
                          wp[pos[k] + 5'd1], wp[pos[k] - 5'd1]});
    end
    s1_raw_c <= wp[12];
    for (int k = 0; k < 4; k++)
        s1_raw_q[k*PIX_BITS +: PIX_BITS] <= wp[pos[k+1]];
end

// ********************
// stage 2: direction pick
// ********************
always_comb begin
    for (int k = 0; k < 5; k++) begin
        if (s1_dh[k] < s1_dv[k])
            g_sel[k] = s1_ah[k];
        else if (s1_dv[k] < s1_dh[k])
            g_sel[k] = s1_av[k];
        else
            g_sel[k] = s1_a4[k];   // no preferred direction
    end
end

always_ff @(posedge pclk) begin
    if ((s1_site == SITE_GR) || (s1_site == SITE_GB))
        g_center <= s1_raw_c;
    else
        g_center <= g_sel[0];
    for (int k = 0; k < 4; k++)
        g_near[k*PIX_BITS +: PIX_BITS] <= g_sel[k+1];
    rb_center <= s1_raw_c;
    rb_near   <= s1_raw_q;
end

always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
        s1_site <= SITE_R;
        g_site  <= SITE_R;
    end else begin
        s1_site <= win_site;
        g_site  <= s1_site;
    end
end

endmodule

//--- source/bayer_window.sv
// Bayer input window
// four line memories feed a 5x5 raw window; adds flush columns and lines,
// and tags every window centre with its site and border flag
`timescale 1ns/1ps

module bayer_window
    import demosaic_pixel_pkg::*;
    import demosaic_frame_pkg::*;
(
    input  logic    pclk,
    input  logic    rst_n,
    input  logic    in_vsync,
    input  logic    in_href,
    input  pix_t    in_raw,
    output window_t win,
    output site_e   win_site,
    output logic    win_valid,
    output logic    win_vsync,
    output logic    win_border,
    output pix_t    win_raw
);

typedef enum logic [1:0] {ST_WAIT, ST_LINES, ST_FLUSH} state_e;
typedef logic [$clog2(MIN_HBLANK + 1)-1:0] idle_cnt_t;

state_e    state;
row_cnt_t  row_cnt;              // input row, flush lines included
col_cnt_t  col_cnt;              // input slot within the line
logic      slot;                 // a window column enters this cycle
logic      col_in_line;
logic      line_end;
pix_t      in_pix;
pix_t      tap [4];              // rows r+1 .. r-2 at this column
pix_t      new_col [5];
pix_t      line_mem [4][FRAME_WIDTH];
idle_cnt_t idle_cnt;

assign col_in_line = (col_cnt < col_cnt_t'(FRAME_WIDTH));
assign line_end    = (col_cnt == col_cnt_t'(FRAME_WIDTH + 1));
assign in_pix      = in_href ? in_raw : '0;   // flush slots read zeros
assign win_raw     = win[12*PIX_BITS +: PIX_BITS];

always_comb begin
    case (state)
        ST_LINES: slot = in_href || !col_in_line;   // pixel or flush column
        ST_FLUSH: slot = 1'b1;                      // flush lines run back to back
        default:  slot = 1'b0;
    endcase
end

// ********************
// slot counters
// ********************
always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
        state   <= ST_WAIT;
        row_cnt <= '0;
        col_cnt <= '0;
    end else if (in_vsync) begin
        state   <= ST_LINES;
        row_cnt <= '0;
        col_cnt <= '0;
    end else if (slot) begin
        if (line_end) begin
            col_cnt <= '0;
            if (row_cnt == row_cnt_t'(FRAME_HEIGHT + 1)) begin
                row_cnt <= '0;
                state   <= ST_WAIT;             // frame fully flushed
            end else begin
                row_cnt <= row_cnt + 1'b1;
                if (row_cnt == row_cnt_t'(FRAME_HEIGHT - 1))
                    state <= ST_FLUSH;
            end
        end else begin
            col_cnt <= col_cnt + 1'b1;
        end
    end
end

// ********************
// line memories
// ********************
always_comb begin
    for (int i = 0; i < 4; i++)
        tap[i] = col_in_line ? line_mem[i][col_addr_t'(col_cnt)] : '0;
    new_col[0] = tap[3];   // top row of the window
    new_col[1] = tap[2];
    new_col[2] = tap[1];
    new_col[3] = tap[0];
    new_col[4] = in_pix;
end

always_ff @(posedge pclk) begin
    if (slot && col_in_line) begin
        line_mem[0][col_addr_t'(col_cnt)] <= in_pix;
        for (int i = 1; i < 4; i++)
            line_mem[i][col_addr_t'(col_cnt)] <= tap[i-1];   // each line moves down
    end
end

always_ff @(posedge pclk) begin
    if (slot) begin
        for (int r = 0; r < 5; r++) begin
            for (int c = 0; c < 4; c++)
                win[(r*5+c)*PIX_BITS +: PIX_BITS] <= win[(r*5+c+1)*PIX_BITS +: PIX_BITS];
            win[(r*5+4)*PIX_BITS +: PIX_BITS] <= new_col[r];
        end
    end
end

// tags of the window centre (r,c); slot parity equals centre parity
always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
        win_vsync  <= 1'b0;
        win_valid  <= 1'b0;
        win_border <= 1'b0;
        win_site   <= SITE_R;
    end else begin
        win_vsync <= in_vsync;
        win_valid <= slot && (row_cnt >= 2) && (col_cnt >= 2);
        if (slot) begin
            win_site   <= site_e'({row_cnt[0], col_cnt[0]} ^ BAYER_PATTERN);
            win_border <= (row_cnt < 4) || (row_cnt >= row_cnt_t'(FRAME_HEIGHT))
                       || (col_cnt < 4) || (col_cnt >= col_cnt_t'(FRAME_WIDTH));
        end
    end
end

// idle cycles since the last href, saturating
always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n)
        idle_cnt <= idle_cnt_t'(MIN_HBLANK);
    else if (in_href)
        idle_cnt <= '0;
    else if (idle_cnt < idle_cnt_t'(MIN_HBLANK))
        idle_cnt <= idle_cnt + 1'b1;
end

href_len_a: assert property (@(posedge pclk) disable iff (!rst_n)
    in_href |-> col_in_line);

hblank_a: assert property (@(posedge pclk) disable iff (!rst_n)
    $rose(in_href) |-> idle_cnt >= idle_cnt_t'(MIN_HBLANK));

endmodule

//--- source/demosaic_pixel_pkg.sv
// Demosaic pixel description
// pixel, window and site types plus the averaging helpers
package demosaic_pixel_pkg;

    localparam int PIX_BITS = 8;

    typedef logic [PIX_BITS-1:0]    pix_t;
    typedef logic [PIX_BITS+1:0]    pix_sum_t;   // room for four pixels
    typedef logic [4*PIX_BITS-1:0]  quad_pix_t;  // L,R,U,D or UL,UR,DL,DR
    typedef logic [25*PIX_BITS-1:0] window_t;    // row-major, centre at 12

    typedef enum logic [1:0] {
        SITE_R  = 2'd0,
        SITE_GR = 2'd1,   // green on a red row
        SITE_GB = 2'd2,   // green on a blue row
        SITE_B  = 2'd3
    } site_e;

    function automatic pix_t quad_pix(input quad_pix_t q, input int k);
        return q[k*PIX_BITS +: PIX_BITS];
    endfunction

    function automatic pix_t avg2(input pix_t a, input pix_t b);
        pix_sum_t s;
        s = pix_sum_t'(a) + pix_sum_t'(b);
        return s[PIX_BITS:1];                // floored
    endfunction

    function automatic pix_t avg4(input quad_pix_t q);
        pix_sum_t s;
        s = pix_sum_t'(quad_pix(q, 0)) + pix_sum_t'(quad_pix(q, 1))
          + pix_sum_t'(quad_pix(q, 2)) + pix_sum_t'(quad_pix(q, 3));
        return s[PIX_BITS+1:2];              // floored
    endfunction

endpackage

//--- source/demosaic_frame_pkg.sv
// Demosaic frame description
// geometry, blanking rules, Bayer pattern and pipeline latencies
package demosaic_frame_pkg;

    localparam int FRAME_WIDTH      = 16;   // active pixels per line
    localparam int FRAME_HEIGHT     = 10;   // active lines per frame
    localparam int MIN_HBLANK       = 4;    // two of these carry the flush columns
    localparam int MIN_VBLANK_LINES = 3;    // idle line slots before next vsync

    // colour order of pixel (0,0); bit 1 flips row parity, bit 0 column parity
    typedef enum logic [1:0] {
        RGGB = 2'd0,
        GRBG = 2'd1,
        GBRG = 2'd2,
        BGGR = 2'd3
    } bayer_pattern_e;

    localparam bayer_pattern_e BAYER_PATTERN = RGGB;

    localparam int WINDOW_LATENCY = 1;  // sample of (r+2,c+2) to window of (r,c)
    localparam int PIPE_LATENCY   = 5;  // window to output pixel

    typedef logic [$clog2(FRAME_HEIGHT + 2)-1:0] row_cnt_t;  // includes flush lines
    typedef logic [$clog2(FRAME_WIDTH + 2)-1:0]  col_cnt_t;  // includes flush columns
    typedef logic [$clog2(FRAME_WIDTH)-1:0]      col_addr_t; // line memory address

endpackage
